//--- sim.f
+incdir+hdl
hdl/llc_pkg.sv
hdl/llc_unlock_arbiter.sv
hdl/llc_tag_store.sv
hdl/llc_lock_table.sv
hdl/llc_miss_counters.sv
hdl/llc_hit_miss.sv
verif/llc_hit_miss_assertions.sv
verif/llc_hit_miss_tb.sv

//--- Makefile
# Verilator build and run for the llc hit/miss unit testbench

VERILATOR ?= verilator
TOP       ?= llc_hit_miss_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) hdl/llc_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/llc_hit_miss_tb.sv
// testbench for the llc hit/miss unit: table-driven stimulus checked against a reference model
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_hit_miss_tb;
  import llc_pkg::*;

  // one table row with its stimulus and the expected output side
  typedef struct packed {
    addr_t      addr;
    id_t        id;
    logic       rw;
    logic [1:0] unl;       // 0 none, 1 read side, 2 write side, 3 both at once
    logic [1:0] downs;     // cnt_down pulses after the transfer
    logic       exp_miss;
  } entry_t;

  localparam int N_ENTRIES     = 22;
  localparam int CYC_PER_ENTRY = 60;
  localparam int CNT_MAX       = (1 << `LLC_CNT_W) - 1;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  llc_desc_t desc_i, desc_o;
  logic      valid_i, ready_o;
  logic      hit_valid_o, hit_ready_i, miss_valid_o, miss_ready_i;
  llc_lock_t r_unlock_i, w_unlock_i;
  logic      r_unlock_req_i, w_unlock_req_i, r_unlock_gnt_o, w_unlock_gnt_o;
  llc_cnt_t  cnt_down_i;

  // reference model state
  tag_t        m_tag   [`LLC_SETS][`LLC_WAYS];
  way_ind_t    m_valid [`LLC_SETS];
  way_ind_t    m_dirty [`LLC_SETS];
  int          m_ptr   [`LLC_SETS];
  way_ind_t    m_lock  [`LLC_SETS];
  int          m_cnt   [1 << `LLC_ID_W];
  entry_t      table_q [N_ENTRIES];
  logic [31:0] lfsr_q;
  int          cyc;

  llc_hit_miss dut0 (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic entry_t mk(input addr_t a, input id_t id, input logic rw,
                                input logic [1:0] unl, input logic [1:0] downs,
                                input logic exp_miss);
    mk = '{a, id, rw, unl, downs, exp_miss};
  endfunction

  // galois lfsr stepped once per bit taken
  function automatic logic rand_bit();
    rand_bit = lfsr_q[0];
    lfsr_q   = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
  endfunction

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch");
    end
  endtask

  // all tasks start and end 1 ns after a rising edge
  task automatic send_desc(input llc_desc_t d);
    logic acc;
    desc_i  = d;
    valid_i = 1'b1;
    acc     = 1'b0;
    while (!acc) begin
      @(negedge clk_i);
      acc = ready_o;
      @(posedge clk_i);
      #1;
    end
    valid_i = 1'b0;
  endtask

  task automatic expect_idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      check_val("valid while blocked", {hit_valid_o, miss_valid_o}, 0);
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic pulse_down(input id_t id);
    cnt_down_i = '{id, 1'b1};
    @(posedge clk_i);
    #1;
    cnt_down_i = '0;
    if (m_cnt[id] > 0) m_cnt[id]--;
  endtask

  // request/grant unlock of one line with each request held until granted
  task automatic unlock_line(input index_t idx, input int way, input logic [1:0] mode);
    llc_lock_t l;
    int        rc, wc;
    logic      rg, wg;
    l              = '{idx, way_ind_t'(1 << way)};
    // a side without a request shows a different line
    r_unlock_i     = mode[0] ? l : ~l;
    w_unlock_i     = mode[1] ? l : ~l;
    r_unlock_req_i = mode[0];
    w_unlock_req_i = mode[1];
    rc             = -1;
    wc             = -2;
    while (r_unlock_req_i || w_unlock_req_i) begin
      @(negedge clk_i);
      rg = r_unlock_gnt_o;
      wg = w_unlock_gnt_o;
      check_val("both unlock grants", rg & wg, 0);
      if (rg) rc = cyc;
      if (wg) wc = cyc;
      @(posedge clk_i);
      #1;
      if (rg) r_unlock_req_i = 1'b0;
      if (wg) w_unlock_req_i = 1'b0;
    end
    if (mode == 2'b11) begin
      check_val("cycles between the two unlock grants", (rc > wc) ? rc - wc : wc - rc, 1);
    end
    m_lock[idx][way] = 1'b0;
  endtask

  // wait for the offer under random back-pressure and check every offered cycle
  task automatic receive(input llc_desc_t exp, input logic route);
    logic done;
    done = 1'b0;
    while (!done) begin
      hit_ready_i  = rand_bit();
      miss_ready_i = rand_bit();
      @(negedge clk_i);
      if (hit_valid_o || miss_valid_o) begin
        check_val("hit_valid_o", hit_valid_o, !route);
        check_val("miss_valid_o", miss_valid_o, route);
        check_val("desc_o", desc_o, exp);
        done = hit_valid_o ? hit_ready_i : miss_ready_i;
      end
      @(posedge clk_i);
      #1;
    end
    hit_ready_i  = 1'b0;
    miss_ready_i = 1'b0;
    // no second copy of the same descriptor
    @(negedge clk_i);
    check_val("valid after transfer", {hit_valid_o, miss_valid_o}, 0);
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////
  // one table entry through the model and the DUT
  ////////////////////////////////////////
  task automatic run_entry(input entry_t e);
    index_t    idx;
    tag_t      tg;
    int        way;
    logic      hit, evict, route;
    llc_desc_t d, exp;
    idx = e.addr[`LLC_OFFSET_W +: `LLC_INDEX_W];
    tg  = e.addr[`LLC_OFFSET_W + `LLC_INDEX_W +: `LLC_TAG_W];
    hit = 1'b0;
    way = -1;
    for (int w = 0; w < `LLC_WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
        hit = 1'b1;
        way = w;
      end
    end
    // a miss takes the lowest invalid way or else the round-robin pointer
    if (!hit) begin
      for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
        if (!m_valid[idx][w]) way = w;
      end
      if (way < 0) way = m_ptr[idx];
    end
    evict = !hit && m_valid[idx][way] && m_dirty[idx][way];
    d           = '0;
    d.addr      = e.addr;
    d.id        = e.id;
    d.rw        = e.rw;
    exp         = d;
    exp.way_ind = way_ind_t'(1 << way);
    exp.refill  = !hit;
    exp.evict   = evict;
    exp.evict_tag = evict ? m_tag[idx][way] : '0;
    // arrays change at lookup time
    if (hit) begin
      m_dirty[idx][way] = m_dirty[idx][way] | e.rw;
    end else begin
      m_valid[idx][way] = 1'b1;
      m_dirty[idx][way] = e.rw;
      m_tag[idx][way]   = tg;
      m_ptr[idx]        = (m_ptr[idx] + 1) % `LLC_WAYS;
    end
    send_desc(d);
    if (m_lock[idx][way]) begin
      expect_idle(6);
      unlock_line(idx, way, 2'b10);
    end
    if (m_cnt[e.id] == CNT_MAX) begin
      expect_idle(6);
      pulse_down(e.id);
    end
    route = (m_cnt[e.id] != 0) || !hit;
    check_val("table route vs model", route, e.exp_miss);
    receive(exp, route);
    m_lock[idx][way] = 1'b1;
    if (route && m_cnt[e.id] < CNT_MAX) m_cnt[e.id]++;
    if (e.unl != 2'b00) unlock_line(idx, way, e.unl);
    repeat (e.downs) pulse_down(e.id);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    arst_n_i       = 1'b0;
    desc_i         = '0;
    valid_i        = 1'b0;
    hit_ready_i    = 1'b0;
    miss_ready_i   = 1'b0;
    r_unlock_i     = '0;
    w_unlock_i     = '0;
    r_unlock_req_i = 1'b0;
    w_unlock_req_i = 1'b0;
    cnt_down_i     = '0;
    cyc            = 0;
    lfsr_q         = 32'he19f_d300;
    for (int s = 0; s < `LLC_SETS; s++) begin
      m_valid[s] = '0;
      m_dirty[s] = '0;
      m_ptr[s]   = 0;
      m_lock[s]  = '0;
    end
    for (int i = 0; i < (1 << `LLC_ID_W); i++) m_cnt[i] = 0;
    // miss then hit on one line
    table_q[0]  = mk(16'h1010, 2'd0, 1'b0, 2'd1, 2'd1, 1'b1);
    table_q[1]  = mk(16'h1010, 2'd0, 1'b0, 2'd1, 2'd0, 1'b0);
    // five write misses in set 2 where the last evicts way 0
    table_q[2]  = mk(16'h2120, 2'd1, 1'b1, 2'd2, 2'd1, 1'b1);
    table_q[3]  = mk(16'h2220, 2'd1, 1'b1, 2'd2, 2'd1, 1'b1);
    table_q[4]  = mk(16'h2320, 2'd1, 1'b1, 2'd2, 2'd1, 1'b1);
    table_q[5]  = mk(16'h2420, 2'd1, 1'b1, 2'd2, 2'd1, 1'b1);
    table_q[6]  = mk(16'h2520, 2'd1, 1'b1, 2'd2, 2'd1, 1'b1);
    // the next access waits on the line left locked and both sides unlock it after
    table_q[7]  = mk(16'h2520, 2'd2, 1'b0, 2'd0, 2'd0, 1'b0);
    table_q[8]  = mk(16'h2520, 2'd2, 1'b0, 2'd3, 2'd0, 1'b0);
    // hit steered to miss while its ID has a miss in flight
    table_q[9]  = mk(16'h3030, 2'd3, 1'b0, 2'd1, 2'd0, 1'b1);
    table_q[10] = mk(16'h1010, 2'd3, 1'b0, 2'd1, 2'd2, 1'b1);
    // seven misses saturate ID 0 and the eighth stalls
    for (int i = 0; i < 7; i++) begin
      table_q[11 + i] = mk(addr_t'(16'h4140 + (i << 8)), 2'd0, 1'b0, 2'd1, 2'd0, 1'b1);
    end
    table_q[18] = mk(16'h4840, 2'd0, 1'b0, 2'd1, 2'd3, 1'b1);
    table_q[19] = mk(16'h1010, 2'd1, 1'b1, 2'd2, 2'd0, 1'b0);
    table_q[20] = mk(16'h5a50, 2'd2, 1'b1, 2'd1, 2'd1, 1'b1);
    table_q[21] = mk(16'h5a50, 2'd2, 1'b0, 2'd3, 2'd0, 1'b0);

    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    // a descriptor offered during the clear sweep must not be taken
    desc_i  = '0;
    valid_i = 1'b1;
    repeat (`LLC_SETS) begin
      @(negedge clk_i);
      check_val("ready_o during clear", ready_o, 0);
      check_val("valids during clear", {hit_valid_o, miss_valid_o}, 0);
      check_val("grants during clear", {r_unlock_gnt_o, w_unlock_gnt_o}, 0);
      @(posedge clk_i);
      #1;
    end
    for (int i = 0; i < N_ENTRIES; i++) run_entry(table_q[i]);
    $display("Test passed");
    $finish;
  end

  // watchdog
  initial begin
    #((N_ENTRIES * CYC_PER_ENTRY + `LLC_SETS + 20) * 8);
    $display("Timeout: the DUT stopped responding before all entries were applied");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verif/llc_hit_miss_assertions.sv
// output protocol assertions for the llc hit/miss unit, bound into the top level
`timescale 1ns/1ps

module llc_hit_miss_assertions (
  input logic               clk_i,
  input logic               arst_n_i,
  input llc_pkg::llc_desc_t desc_o,
  input logic               hit_valid_o,
  input logic               hit_ready_i,
  input logic               miss_valid_o,
  input logic               miss_ready_i
);

  // only one output offers at a time
  a_one_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(hit_valid_o && miss_valid_o)) else $error("hit and miss valid both high");

  // offered descriptor targets exactly one way
  a_way_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (hit_valid_o || miss_valid_o) |-> $onehot(desc_o.way_ind))
    else $error("way indicator not one-hot");

  // back-pressure keeps valid and descriptor
  a_hit_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (hit_valid_o && !hit_ready_i) |=> (hit_valid_o && $stable(desc_o)))
    else $error("hit output changed under back-pressure");

  a_miss_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (miss_valid_o && !miss_ready_i) |=> (miss_valid_o && $stable(desc_o)))
    else $error("miss output changed under back-pressure");

endmodule

bind llc_hit_miss llc_hit_miss_assertions i_assertions (.*);

//--- hdl/llc_hit_miss.sv
// llc hit/miss unit: looks up one descriptor at a time and steers it to the hit or miss output
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_hit_miss (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  llc_pkg::llc_desc_t desc_i,
  input  logic               valid_i,
  output logic               ready_o,
  output llc_pkg::llc_desc_t desc_o,
  output logic               hit_valid_o,
  input  logic               hit_ready_i,
  output logic               miss_valid_o,
  input  logic               miss_ready_i,
  input  llc_pkg::llc_lock_t r_unlock_i,
  input  logic               r_unlock_req_i,
  output logic               r_unlock_gnt_o,
  input  llc_pkg::llc_lock_t w_unlock_i,
  input  logic               w_unlock_req_i,
  output logic               w_unlock_gnt_o,
  input  llc_pkg::llc_cnt_t  cnt_down_i
);
  import llc_pkg::*;

  hm_state_e state_q, state_d;
  llc_desc_t desc_q;
  logic      load_desc;
  // steering frozen once offered
  logic      hold_q, hold_d;
  logic      hold_miss_q;

  tag_req_t  tag_req;
  logic      tag_req_valid, tag_req_ready;
  tag_res_t  tag_res;
  logic      tag_res_valid, tag_res_ready;

  llc_lock_t lock;
  logic      lock_req, locked;
  llc_cnt_t  cnt_up;
  logic      to_miss, cnt_stall;

  logic      route_miss, offer;
  logic      hit_xfer, miss_xfer, out_xfer;

  ////////////////////////////////////////
  // output steering
  ////////////////////////////////////////
  always_comb begin
    desc_o = desc_q;
    // lookup result overrides the way and the refill/evict fields
    if (tag_res_valid) begin
      desc_o.way_ind   = tag_res.way_ind;
      desc_o.refill    = ~tag_res.hit;
      desc_o.evict     = tag_res.evict;
      desc_o.evict_tag = tag_res.evict_tag;
    end
  end

  // hits of an ID with misses in flight go the miss way too
  assign route_miss = hold_q ? hold_miss_q : (to_miss | ~tag_res.hit);
  assign offer      = (state_q == HM_BUSY) & tag_res_valid & ~locked & ~cnt_stall;

  assign hit_valid_o  = offer & ~route_miss;
  assign miss_valid_o = offer &  route_miss;
  assign hit_xfer     = hit_valid_o & hit_ready_i;
  assign miss_xfer    = miss_valid_o & miss_ready_i;
  assign out_xfer     = hit_xfer | miss_xfer;

  assign tag_res_ready = out_xfer;

  ////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////
  always_comb begin
    state_d       = state_q;
    ready_o       = 1'b0;
    tag_req_valid = 1'b0;
    load_desc     = 1'b0;
    case (state_q)
      // wait for the tag store sweep
      HM_INIT: begin
        if (tag_req_ready) begin
          state_d = HM_IDLE;
        end
      end
      HM_IDLE: begin
        tag_req_valid = valid_i;
        if (valid_i && tag_req_ready) begin
          ready_o   = 1'b1;
          load_desc = 1'b1;
          state_d   = HM_BUSY;
        end
      end
      HM_BUSY: begin
        // next lookup may start while the current descriptor leaves
        if (out_xfer) begin
          tag_req_valid = valid_i;
          if (valid_i && tag_req_ready) begin
            ready_o   = 1'b1;
            load_desc = 1'b1;
          end else begin
            state_d = HM_IDLE;
          end
        end
      end
      default: state_d = HM_INIT;
    endcase
  end

  always_comb begin
    hold_d = hold_q;
    if (out_xfer) begin
      hold_d = 1'b0;
    end else if (offer) begin
      hold_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= HM_INIT;
      hold_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      hold_q  <= hold_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_desc) begin
      desc_q <= desc_i;
    end
    if (offer && !hold_q) begin
      hold_miss_q <= route_miss;
    end
  end

  ////////////////////////////////////////
  // submodules
  ////////////////////////////////////////
  assign tag_req.index = desc_i.addr[`LLC_OFFSET_W +: `LLC_INDEX_W];
  assign tag_req.tag   = desc_i.addr[`LLC_OFFSET_W + `LLC_INDEX_W +: `LLC_TAG_W];
  assign tag_req.dirty = desc_i.rw;

  llc_tag_store i_tag_store (
    .clk_i       ( clk_i         ),
    .arst_n_i    ( arst_n_i      ),
    .req_i       ( tag_req       ),
    .req_valid_i ( tag_req_valid ),
    .req_ready_o ( tag_req_ready ),
    .res_o       ( tag_res       ),
    .res_valid_o ( tag_res_valid ),
    .res_ready_i ( tag_res_ready )
  )

;

  // lock the line on any transfer
  assign lock.index   = desc_q.addr[`LLC_OFFSET_W +: `LLC_INDEX_W];
  assign lock.way_ind = tag_res.way_ind;
  assign lock_req     = out_xfer;

  llc_lock_table i_lock_table (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .lock_i         ( lock           ),
    .lock_req_i     ( lock_req       ),
    .locked_o       ( locked         ),
    .r_unlock_i     ( r_unlock_i     ),
    .r_unlock_req_i ( r_unlock_req_i ),
    .r_unlock_gnt_o ( r_unlock_gnt_o ),
    .w_unlock_i     ( w_unlock_i     ),
    .w_unlock_req_i ( w_unlock_req_i ),
    .w_unlock_gnt_o ( w_unlock_gnt_o )
  );

  // count each descriptor sent down the miss path
  assign cnt_up.id    = desc_q.id;
  assign cnt_up.valid = miss_xfer;

  llc_miss_counters i_miss_counters (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .cnt_up_i   ( cnt_up     ),
    .cnt_down_i ( cnt_down_i ),
    .id_i       ( desc_q.id  ),
    .to_miss_o  ( to_miss    ),
    .stall_o    ( cnt_stall  )
  );

endmodule

//--- hdl/llc_miss_counters.sv
// llc miss counters: outstanding misses per ID, driving the to-miss and stall flags
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_miss_counters (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  llc_pkg::llc_cnt_t cnt_up_i,
  input  llc_pkg::llc_cnt_t cnt_down_i,
  input  llc_pkg::id_t      id_i,
  output logic              to_miss_o,
  output logic              stall_o
);
  import llc_pkg::*;

  cnt_val_t cnt_q [1 << `LLC_ID_W];
  cnt_val_t cnt_d [1 << `LLC_ID_W];

  ////////////////////////////////////////
  // counter update
  ////////////////////////////////////////
  always_comb begin
    cnt_d = cnt_q;
    for (int i = 0; i < (1 << `LLC_ID_W); i++) begin
      // up and down on one ID in one cycle cancel
      if (cnt_up_i.valid && (cnt_up_i.id == id_t'(i)) &&
          !(cnt_down_i.valid && (cnt_down_i.id == id_t'(i)))) begin
        if (cnt_q[i] != '1) begin
          cnt_d[i] = cnt_q[i] + cnt_val_t'(1);
        end
      end else if (cnt_down_i.valid && (cnt_down_i.id == id_t'(i)) &&
                   !(cnt_up_i.valid && (cnt_up_i.id == id_t'(i)))) begin
        if (cnt_q[i] != '0) begin
          cnt_d[i] = cnt_q[i] - cnt_val_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < (1 << `LLC_ID_W); i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // flags for the held descriptor's ID
  assign to_miss_o = (cnt_q[id_i] != '0);
  assign stall_o   = (cnt_q[id_i] == '1);

endmodule

//--- hdl/llc_lock_table.sv
// llc lock table: one lock bit per set and way, with arbitrated read/write unlocks
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_lock_table (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  llc_pkg::llc_lock_t lock_i,
  input  logic               lock_req_i,
  output logic               locked_o,
  input  llc_pkg::llc_lock_t r_unlock_i,
  input  logic               r_unlock_req_i,
  output logic               r_unlock_gnt_o,
  input  llc_pkg::llc_lock_t w_unlock_i,
  input  logic               w_unlock_req_i,
  output logic               w_unlock_gnt_o
);
  import llc_pkg::*;

  way_ind_t  lock_q [`LLC_SETS];
  way_ind_t  lock_d [`LLC_SETS];
  llc_lock_t unlock;
  logic      unlock_valid;

  // at most one unlock per cycle
  llc_unlock_arbiter i_unlock_arbiter (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .r_req_i  ( r_unlock_req_i ),
    .w_req_i  ( w_unlock_req_i ),
    .r_gnt_o  ( r_unlock_gnt_o ),
    .w_gnt_o  ( w_unlock_gnt_o )
  );

  assign unlock       = r_unlock_gnt_o ? r_unlock_i : w_unlock_i;
  assign unlock_valid = r_unlock_gnt_o | w_unlock_gnt_o;

  // state of the line presented by the top
  assign locked_o = |(lock_q[lock_i.index] & lock_i.way_ind);

  ////////////////////////////////////////
  // lock bit update
  ////////////////////////////////////////
  always_comb begin
    lock_d = lock_q;
    // granted unlock clears with the grant
    if (unlock_valid) begin
      lock_d[unlock.index] = lock_d[unlock.index] & ~unlock.way_ind;
    end
    // a new lock on the same line wins
    if (lock_req_i) begin
      lock_d[lock_i.index] = lock_d[lock_i.index] | lock_i.way_ind;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < `LLC_SETS; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      lock_q <= lock_d;
    end
  end

endmodule

//--- hdl/llc_tag_store.sv
// llc tag store: tag/valid/dirty arrays with lookup, replacement and post-reset clear
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_tag_store (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  llc_pkg::tag_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output llc_pkg::tag_res_t res_o,
  output logic              res_valid_o,
  input  logic              res_ready_i
);
  import llc_pkg::*;

  // storage, one entry per set
  tag_t      tag_q   [`LLC_SETS][`LLC_WAYS];
  way_ind_t  valid_q [`LLC_SETS];
  way_ind_t  dirty_q [`LLC_SETS];
  way_ind_t  ptr_q   [`LLC_SETS];   // one-hot round-robin victim pointer

  ts_state_e state_q;
  index_t    clr_idx_q;

  // lookup
  way_ind_t  hit_vec;
  way_ind_t  inv_vec;
  way_ind_t  victim;
  tag_t      victim_tag;
  logic      hit;
  logic      accept;

  tag_res_t  res_d;
  tag_res_t  res_q;
  logic      res_valid_q;

  ////////////////////////////////////////
  // clear sweep
  ////////////////////////////////////////
  // one set per cycle, then run
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= TS_CLEAR;
      clr_idx_q <= '0;
    end else if (state_q == TS_CLEAR) begin
      clr_idx_q <= clr_idx_q + index_t'(1);
      if (clr_idx_q == index_t'(`LLC_SETS - 1)) begin
        state_q <= TS_RUN;
      end
    end
  end

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////
  // next request only once the old result is gone or leaving
  assign req_ready_o = (state_q == TS_RUN) & (~res_valid_q | res_ready_i);
  assign accept      = req_valid_i & req_ready_o;

  always_comb begin
    hit_vec    = '0;
    victim_tag = '0;
    // lowest invalid way first, else the pointer's way
    inv_vec = ~valid_q[req_i.index];
    victim  = (|inv_vec) ? (inv_vec & (~inv_vec + way_ind_t'(1))) : ptr_q[req_i.index];
    for (int w = 0; w < `LLC_WAYS; w++) begin
      hit_vec[w] = valid_q[req_i.index][w] & (tag_q[req_i.index][w] == req_i.tag);
      if (victim[w]) begin
        victim_tag = tag_q[req_i.index][w];
      end
    end
    hit = |hit_vec;

    res_d.hit     = hit;
    res_d.way_ind = hit ? hit_vec : victim;
    // a valid dirty victim has to be written back
    res_d.evict     = ~hit & (|(victim & valid_q[req_i.index] & dirty_q[req_i.index]));
    res_d.evict_tag = res_d.evict ? victim_tag : '0;
  end

  ////////////////////////////////////////
  // array update
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (state_q == TS_CLEAR) begin
      valid_q[clr_idx_q] <= '0;
      dirty_q[clr_idx_q] <= '0;
      ptr_q[clr_idx_q]   <= way_ind_t'(1);
    end else if (accept) begin
      if (hit) begin
        // writes mark the line dirty
        dirty_q[req_i.index] <= dirty_q[req_i.index] | (hit_vec & {`LLC_WAYS{req_i.dirty}});
      end else begin
        valid_q[req_i.index] <= valid_q[req_i.index] | victim;
        dirty_q[req_i.index] <= (dirty_q[req_i.index] & ~victim) |
                                (victim & {`LLC_WAYS{req_i.dirty}});
        // rotate pointer on every miss
        ptr_q[req_i.index]   <= {ptr_q[req_i.index][`LLC_WAYS-2:0],
                                 ptr_q[req_i.index][`LLC_WAYS-1]};
        for (int w = 0; w < `LLC_WAYS; w++) begin
          if (victim[w]) begin
            tag_q[req_i.index][w] <= req_i.tag;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // response register
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (accept) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  // result held until taken
  always_ff @(posedge clk_i) begin
    if (accept) begin
      res_q <= res_d;
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

endmodule

//--- hdl/llc_unlock_arbiter.sv
// round-robin arbiter between the read and write unlock requesters
`timescale 1ns/1ps

module llc_unlock_arbiter (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic r_req_i,
  input  logic w_req_i,
  output logic r_gnt_o,
  output logic w_gnt_o
);

  // 0: read side wins a conflict, 1: write side wins
  logic prio_q;
  logic contested;

  assign contested = r_req_i & w_req_i;

  // an uncontested request is always served
  assign r_gnt_o = r_req_i & (~w_req_i | ~prio_q);
  assign w_gnt_o = w_req_i & (~r_req_i |  prio_q);

  ////////////////////////////////////////
  // priority flip
  ////////////////////////////////////////
  // swap after each conflict so the loser wins the next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q <= 1'b0;
    end else if (contested) begin
      prio_q <= ~prio_q;
    end
  end

endmodule

//--- hdl/llc_pkg.sv
// llc types: width vectors, descriptor, lock, counter and tag store structs, state enums
`include "llc_params.svh"

package llc_pkg;

  // vectors with a meaning
  typedef logic [`LLC_ADDR_W-1:0]  addr_t;
  typedef logic [`LLC_INDEX_W-1:0] index_t;
  typedef logic [`LLC_TAG_W-1:0]   tag_t;
  typedef logic [`LLC_WAYS-1:0]    way_ind_t;
  typedef logic [`LLC_ID_W-1:0]    id_t;
  typedef logic [`LLC_CNT_W-1:0]   cnt_val_t;

  // descriptor travelling through the unit, 33 bits
  typedef struct packed {
    addr_t    addr;
    id_t      id;
    logic     rw;         // 1 = write
    way_ind_t way_ind;    // one-hot way the access goes to
    logic     refill;     // line must be fetched
    logic     evict;      // victim line is dirty and must be written back
    tag_t     evict_tag;
  } llc_desc_t;

  // lock / unlock of one line
  typedef struct packed {
    index_t   index;
    way_ind_t way_ind;
  } llc_lock_t;

  // miss counter strobe
  typedef struct packed {
    id_t  id;
    logic valid;
  } llc_cnt_t;

  // lookup request to the tag store
  typedef struct packed {
    index_t index;
    tag_t   tag;
    logic   dirty;
  } tag_req_t;

  // lookup result from the tag store
  typedef struct packed {
    way_ind_t way_ind;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

  typedef enum logic [1:0] {HM_INIT, HM_IDLE, HM_BUSY} hm_state_e;
  typedef enum logic {TS_CLEAR, TS_RUN} ts_state_e;

endpackage

//--- hdl/llc_params.svh
// llc geometry and width macros shared by the hit/miss unit and its submodules
`ifndef LLC_PARAMS_SVH
`define LLC_PARAMS_SVH

// address split: tag | index | offset
`define LLC_ADDR_W   16
`define LLC_OFFSET_W 4
`define LLC_INDEX_W  4
`define LLC_TAG_W    8

// set count follows from the index width
`define LLC_SETS     16

// associativity, one bit per way in the way indicator
`define LLC_WAYS     4

// transaction ID width, one miss counter per ID
`define LLC_ID_W     2

// miss counter width, saturates at all ones (7)
`define LLC_CNT_W    3

`endif
